// File: vlog.f
common/loader_pkg.sv
source/addr_config.sv
source/mem_request_unit.sv
source/data_ram.sv
loader/keypad_loader_fsm.sv
source/loader_top.sv
verif/loader_properties.sv
verif/loader_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := loader_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/loader_tb.sv
module loader_tb
    import loader_pkg::*;
();

    localparam int WAIT_LIMIT = 40;
    localparam int NUM_STEPS  = 4;

    typedef struct packed {
        logic [7:0]  key;
        logic [31:0] mask;
    } step_t;

    // Key for each slot, mask on the processor word for the same slot
    step_t steps [NUM_STEPS] = '{
        '{key: 8'h41, mask: 32'hFFFF_FFFF},
        '{key: 8'h37, mask: 32'hFFFF_FF00},
        '{key: 8'h00, mask: 32'hFFFF_FFFF},
        '{key: 8'h5A, mask: 32'h0000_00FF}
    };

    logic          clk;
    logic          nRST;
    logic          en_i;
    key_event_t    key_i;
    logic          cfg_we_i;
    cfg_sel_t      cfg_sel_i;
    logic [31:0]   cfg_data_i;
    logic [31:0]   instr_i;
    mem_req_t      cpu_req_i;
    mem_rsp_t      cpu_rsp_o;
    logic          run_o;
    logic [7:0]    display_o;
    loader_state_t state_o;
    logic          lcd_en_o;

    logic [31:0] model [RAM_WORDS];
    logic [31:0] rng;
    logic [31:0] write_base;
    logic [31:0] read_base;
    int          errors;
    int          checks;

    loader_top i_loader_top (
        .clk        (clk),
        .nRST       (nRST),
        .en_i       (en_i),
        .key_i      (key_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_sel_i  (cfg_sel_i),
        .cfg_data_i (cfg_data_i),
        .instr_i    (instr_i),
        .cpu_req_i  (cpu_req_i),
        .cpu_rsp_o  (cpu_rsp_o),
        .run_o      (run_o),
        .display_o  (display_o),
        .state_o    (state_o),
        .lcd_en_o   (lcd_en_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Viewer shows a zero byte as the character 0
    function automatic logic [7:0] shown_byte(input logic [31:0] addr);
        logic [7:0] b;
        b = model[addr[7:2]][7:0];
        return (b == 8'h00) ? 8'h30 : b;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic press_key(input logic [7:0] code);
        key_i = '{valid: 1'b1, code: code};
        step();
        key_i = '{valid: 1'b0, code: 8'h00};
    endtask

    task automatic wait_state(input loader_state_t target);
        int n;
        n = 0;
        while (state_o != target && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (state_o != target) begin
            $display("Timeout at %0t while waiting for state %s", $time, target.name());
            errors++;
        end
    endtask

    task automatic apply_reset();
        nRST = 1'b0;
        repeat (5) step();
        nRST = 1'b1;
    endtask

    task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data);
        int cycles;
        cpu_req_i = '{read: 1'b0, write: 1'b1, addr: addr, wdata: data};
        step();
        cpu_req_i.write = 1'b0;
        cycles = 1;
        while (!cpu_rsp_o.done && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (!cpu_rsp_o.done) begin
            $display("Timeout at %0t while waiting for done of write to %h", $time, addr);
            errors++;
        end else begin
            check_value("cpu write latency", 32'(cycles), 32'(MEM_LATENCY));
        end
        model[addr[7:2]] = data;
        // The request unit ignores a strobe during its done cycle
        step();
    endtask

    // Read strobe is held until done
    task automatic cpu_read(input logic [31:0] addr);
        int cycles;
        cpu_req_i = '{read: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
        cycles = 0;
        while (!cpu_rsp_o.done && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        cpu_req_i.read = 1'b0;
        if (!cpu_rsp_o.done) begin
            $display("Timeout at %0t while waiting for done of read from %h", $time, addr);
            errors++;
        end else begin
            check_value("cpu read latency", 32'(cycles), 32'(MEM_LATENCY));
            check_value("cpu_rsp_o.rdata", cpu_rsp_o.rdata, model[addr[7:2]]);
        end
        step();
    endtask

    task automatic key_program();
        int i;
        logic [31:0] addr;
        for (i = 0; i < NUM_STEPS; i++) begin
            press_key(steps[i].key);
            check_value("display_o after key", 32'(display_o), 32'(steps[i].key));
            press_key(KEY_STORE);
            wait_state(IDLE);
            check_value("display_o after store", 32'(display_o), 32'h0);
            addr = write_base + 32'(4 * i);
            model[addr[7:2]] = {24'h0, steps[i].key};
        end
        press_key(KEY_NEXT);
        wait_state(ASM);
        check_value("run_o after count write", 32'(run_o), 32'h1);
        model[DEF_NUM_ADDR[7:2]] = 32'(NUM_STEPS);
    endtask

    task automatic view_words();
        int i;
        for (i = 0; i < NUM_STEPS; i++) begin
            wait_state(FLASH);
            check_value("lcd_en_o", 32'(lcd_en_o), 32'h1);
            check_value("display_o", 32'(display_o), 32'(shown_byte(read_base + 32'(4 * i))));
            press_key(KEY_NEXT);
            check_value("lcd_en_o after pulse", 32'(lcd_en_o), 32'h0);
        end
        wait_state(FINISH);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        int i;
        errors     = 0;
        checks     = 0;
        rng        = 32'd89;
        nRST       = 1'b0;
        en_i       = 1'b0;
        key_i      = '0;
        cfg_we_i   = 1'b0;
        cfg_sel_i  = WRITE_BASE_SEL;
        cfg_data_i = 32'h0;
        instr_i    = 32'h0;
        cpu_req_i  = '0;
        write_base = DEF_WRITE_BASE;
        read_base  = DEF_READ_BASE;
        apply_reset();

        check_value("state_o after reset", 32'(state_o), 32'(INIT));
        check_value("display_o after reset", 32'(display_o), 32'h0);
        check_value("run_o after reset", 32'(run_o), 32'h0);
        check_value("lcd_en_o after reset", 32'(lcd_en_o), 32'h0);
        check_value("cpu_rsp_o.done after reset", 32'(cpu_rsp_o.done), 32'h0);
        en_i = 1'b1;
        step();
        check_value("state_o after enable", 32'(state_o), 32'(IDLE));

        // First run fills the read region from the processor side
        key_program();
        for (i = 0; i < NUM_STEPS; i++) begin
            rng = xorshift(rng);
            cpu_write(read_base + 32'(4 * i), rng & steps[i].mask);
        end
        // Slot count stored by the loader
        cpu_read(DEF_NUM_ADDR);
        instr_i = HALT_INSTR;
        wait_state(DISPLAY);
        instr_i = 32'h0;
        check_value("run_o after halt", 32'(run_o), 32'h0);
        view_words();

        // Second run views the keyed words
        en_i = 1'b0;
        apply_reset();
        check_value("state_o after second reset", 32'(state_o), 32'(INIT));
        cfg_we_i   = 1'b1;
        cfg_sel_i  = READ_BASE_SEL;
        cfg_data_i = write_base;
        step();
        cfg_we_i   = 1'b0;
        read_base  = write_base;
        en_i       = 1'b1;
        wait_state(IDLE);
        key_program();
        press_key(KEY_DONE);
        check_value("state_o after D key", 32'(state_o), 32'(DISPLAY));
        check_value("run_o after D key", 32'(run_o), 32'h0);
        view_words();

        errors = errors + i_loader_top.i_keypad_loader_fsm.i_loader_properties.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/loader_properties.sv
module loader_properties
    import loader_pkg::*;
(
    input logic          clk,
    input logic          nRST,
    input logic          done_i,
    input logic          lcd_en_i,
    input logic          run_i,
    input loader_state_t state_i,
    input logic          write_i
);

    int fail_count = 0;

    done_single: assert property (@(posedge clk) disable iff (!nRST) done_i |=> !done_i)
        else begin
            $error("done high on two cycles in a row");
            fail_count++;
        end

    lcd_pulse: assert property (@(posedge clk) disable iff (!nRST) lcd_en_i |=> !lcd_en_i)
        else begin
            $error("lcd_en_o longer than one cycle");
            fail_count++;
        end

    // Processor only runs while the FSM sits in ASM
    run_in_asm: assert property (@(posedge clk) disable iff (!nRST) run_i |-> state_i == ASM)
        else begin
            $error("run_o high outside ASM");
            fail_count++;
        end

    write_pulse: assert property (@(posedge clk) disable iff (!nRST) write_i |=> !write_i)
        else begin
            $error("write strobe longer than one cycle");
            fail_count++;
        end

endmodule

bind keypad_loader_fsm loader_properties i_loader_properties (
    .clk      (clk),
    .nRST     (nRST),
    .done_i   (rsp_i.done),
    .lcd_en_i (lcd_en_o),
    .run_i    (run_o),
    .state_i  (state_o),
    .write_i  (req_o.write)
);

// File: source/loader_top.sv
module loader_top
    import loader_pkg::*;
(
    input  logic          clk,
    input  logic          nRST,
    input  logic          en_i,
    input  key_event_t    key_i,
    input  logic          cfg_we_i,
    input  cfg_sel_t      cfg_sel_i,
    input  logic [31:0]   cfg_data_i,
    input  logic [31:0]   instr_i,
    input  mem_req_t      cpu_req_i,
    output mem_rsp_t      cpu_rsp_o,
    output logic          run_o,
    output logic [7:0]    display_o,
    output loader_state_t state_o,
    output logic          lcd_en_o
);

    base_cfg_t         bases;
    mem_req_t          ldr_req;
    mem_rsp_t          rsp;
    logic              ram_we;
    logic [RAM_AW-1:0] ram_addr;
    logic [31:0]       ram_wdata;
    logic [31:0]       ram_rdata;

    assign cpu_rsp_o = rsp;

    addr_config i_addr_config (
        .clk        (clk),
        .nRST       (nRST),
        .cfg_we_i   (cfg_we_i),
        .cfg_sel_i  (cfg_sel_i),
        .cfg_data_i (cfg_data_i),
        .bases_o    (bases)
    );

    keypad_loader_fsm i_keypad_loader_fsm (
        .clk       (clk),
        .nRST      (nRST),
        .en_i      (en_i),
        .key_i     (key_i),
        .bases_i   (bases),
        .instr_i   (instr_i),
        .rsp_i     (rsp),
        .req_o     (ldr_req),
        .run_o     (run_o),
        .display_o (display_o),
        .state_o   (state_o),
        .lcd_en_o  (lcd_en_o)
    );

    // run_o hands the memory port to the processor
    mem_request_unit i_mem_request_unit (
        .clk         (clk),
        .nRST        (nRST),
        .cpu_sel_i   (run_o),
        .ldr_req_i   (ldr_req),
        .cpu_req_i   (cpu_req_i),
        .rsp_o       (rsp),
        .ram_we_o    (ram_we),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    data_ram i_data_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

// File: loader/keypad_loader_fsm.sv
module keypad_loader_fsm
    import loader_pkg::*;
(
    input  logic          clk,
    input  logic          nRST,
    input  logic          en_i,
    input  key_event_t    key_i,
    input  base_cfg_t     bases_i,
    input  logic [31:0]   instr_i,
    input  mem_rsp_t      rsp_i,
    output mem_req_t      req_o,
    output logic          run_o,
    output logic [7:0]    display_o,
    output loader_state_t state_o,
    output logic          lcd_en_o
);

    loader_state_t state;
    loader_state_t next_state;
    logic [31:0]   slot;
    logic [31:0]   next_slot;
    logic [31:0]   count;
    logic [31:0]   next_count;
    logic          rd_q;
    logic          next_rd;
    logic          wr_q;
    logic          next_wr;
    logic [31:0]   addr_q;
    logic [31:0]   next_addr;
    logic [31:0]   wdata_q;
    logic [31:0]   next_wdata;
    logic          run_q;
    logic          next_run;
    logic          lcd_q;
    logic          next_lcd;
    logic [7:0]    disp_q;
    logic [7:0]    next_disp;
    logic          key_store;
    logic          key_next;
    logic          key_done;

    assign key_store = key_i.valid && (key_i.code == KEY_STORE);
    assign key_next  = key_i.valid && (key_i.code == KEY_NEXT);
    assign key_done  = key_i.valid && (key_i.code == KEY_DONE);

    assign state_o   = state;
    assign run_o     = run_q;
    assign lcd_en_o  = lcd_q;
    assign display_o = disp_q;
    assign req_o     = '{read: rd_q, write: wr_q, addr: addr_q, wdata: wdata_q};

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state  <= INIT;
            slot   <= '0;
            count  <= '0;
            rd_q   <= 1'b0;
            wr_q   <= 1'b0;
            run_q  <= 1'b0;
            lcd_q  <= 1'b0;
            disp_q <= '0;
        end else begin
            state  <= next_state;
            slot   <= next_slot;
            count  <= next_count;
            rd_q   <= next_rd;
            wr_q   <= next_wr;
            run_q  <= next_run;
            lcd_q  <= next_lcd;
            disp_q <= next_disp;
        end
    end

    always_ff @(posedge clk) begin
        addr_q  <= next_addr;
        wdata_q <= next_wdata;
    end

    always_comb begin
        next_state = state;
        next_slot  = slot;
        next_count = count;
        next_rd    = 1'b0;
        next_wr    = 1'b0;
        next_addr  = '0;
        next_wdata = wdata_q;
        next_run   = run_q;
        next_lcd   = 1'b0;
        next_disp  = disp_q;
        case (state)
            INIT: begin
                if (en_i) begin
                    next_state = IDLE;
                end
            end
            IDLE: begin
                if (key_store) begin
                    next_wr    = 1'b1;
                    next_addr  = bases_i.write_base + (slot << 2);
                    next_state = WRITE;
                end else if (key_next) begin
                    next_wr    = 1'b1;
                    next_wdata = slot;
                    next_addr  = bases_i.num_addr;
                    next_count = slot;
                    next_state = NUM;
                end else if (key_i.valid) begin
                    next_wdata = {24'b0, key_i.code};
                    next_disp  = key_i.code;
                end
            end
            WRITE: begin
                if (rsp_i.done) begin
                    next_slot  = slot + 1;
                    next_disp  = '0;
                    next_state = IDLE;
                end
            end
            NUM: begin
                if (rsp_i.done) begin
                    next_slot  = '0;
                    next_wdata = '0;
                    next_run   = 1'b1;
                    next_state = ASM;
                end
            end
            ASM: begin
                // Completed processor accesses
                if (rsp_i.done) begin
                    next_slot = slot + 1;
                end
                if (key_done || (instr_i == HALT_INSTR)) begin
                    next_run   = 1'b0;
                    next_slot  = '0;
                    next_state = DISPLAY;
                end
            end
            DISPLAY: begin
                if (key_store || (slot == count)) begin
                    next_slot  = '0;
                    next_count = '0;
                    next_state = FINISH;
                end else begin
                    next_rd    = 1'b1;
                    next_addr  = bases_i.read_base + (slot << 2);
                    next_state = FETCH;
                end
            end
            FETCH: begin
                // Read strobe and address stay up until done
                next_rd   = rd_q;
                next_addr = addr_q;
                if (rsp_i.done) begin
                    next_rd    = 1'b0;
                    next_addr  = '0;
                    next_slot  = slot + 1;
                    next_lcd   = 1'b1;
                    next_disp  = (rsp_i.rdata[7:0] == 8'h00) ? CHAR_ZERO : rsp_i.rdata[7:0];
                    next_state = FLASH;
                end
            end
            FLASH: begin
                if (key_next) begin
                    next_disp  = '0;
                    next_state = DISPLAY;
                end
            end
            FINISH: begin
                next_state = FINISH;
            end
            default: begin
                next_state = INIT;
            end
        endcase
    end

endmodule

// File: source/data_ram.sv
module data_ram
    import loader_pkg::*;
(
    input  logic              clk,
    input  logic              we_i,
    input  logic [RAM_AW-1:0] addr_i,
    input  logic [31:0]       wdata_i,
    output logic [31:0]       rdata_o
);

    logic [31:0] mem [RAM_WORDS];

    // Registered read returns the old word on a write
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

// File: source/mem_request_unit.sv
module mem_request_unit
    import loader_pkg::*;
(
    input  logic              clk,
    input  logic              nRST,
    input  logic              cpu_sel_i,
    input  mem_req_t          ldr_req_i,
    input  mem_req_t          cpu_req_i,
    output mem_rsp_t          rsp_o,
    output logic              ram_we_o,
    output logic [RAM_AW-1:0] ram_addr_o,
    output logic [31:0]       ram_wdata_o,
    input  logic [31:0]       ram_rdata_i
);

    mem_req_t          req;
    logic              accept;
    logic              last;
    logic              busy;
    logic              done_q;
    logic [LAT_W-1:0]  cnt;
    logic [RAM_AW-1:0] addr_q;
    logic [31:0]       rdata_q;

    // Processor owns the port while it runs
    assign req = cpu_sel_i ? cpu_req_i : ldr_req_i;

    // The done cycle is not idle, so a read strobe still held
    // by its requester is not taken a second time
    assign accept = !busy && !done_q && (req.read || req.write);
    assign last   = busy && (cnt == LAT_W'(MEM_LATENCY - 1));

    assign ram_we_o    = accept && req.write;
    assign ram_wdata_o = req.wdata;
    // Hold the captured word on the RAM while waiting out the latency
    assign ram_addr_o  = busy ? addr_q : req.addr[RAM_AW+1:2];

    assign rsp_o = '{done: done_q, rdata: rdata_q};

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= LAT_W'(1);
            end else if (last) begin
                busy   <= 1'b0;
                cnt    <= '0;
                done_q <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req.addr[RAM_AW+1:2];
        end
        if (last) begin
            rdata_q <= ram_rdata_i;
        end
    end

endmodule

// File: source/addr_config.sv
module addr_config
    import loader_pkg::*;
(
    input  logic        clk,
    input  logic        nRST,
    input  logic        cfg_we_i,
    input  cfg_sel_t    cfg_sel_i,
    input  logic [31:0] cfg_data_i,
    output base_cfg_t   bases_o
);

    base_cfg_t bases_q;

    assign bases_o = bases_q;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            bases_q.write_base <= DEF_WRITE_BASE;
            bases_q.read_base  <= DEF_READ_BASE;
            bases_q.num_addr   <= DEF_NUM_ADDR;
        end else if (cfg_we_i) begin
            case (cfg_sel_i)
                WRITE_BASE_SEL: begin
                    bases_q.write_base <= cfg_data_i;
                end
                READ_BASE_SEL: begin
                    bases_q.read_base <= cfg_data_i;
                end
                NUM_ADDR_SEL: begin
                    bases_q.num_addr <= cfg_data_i;
                end
                default: begin
                    // Unused select code leaves all bases alone
                    bases_q <= bases_q;
                end
            endcase
        end
    end

endmodule

// File: common/loader_pkg.sv
package loader_pkg;

    // Keypad character codes
    localparam logic [7:0] KEY_STORE = "*";
    localparam logic [7:0] KEY_NEXT  = "#";
    localparam logic [7:0] KEY_DONE  = "D";
    localparam logic [7:0] CHAR_ZERO = "0";

    // Processor halt word
    localparam logic [31:0] HALT_INSTR = 32'h6000_2023;

    // Cycles from an accepted request to its done pulse
    localparam int MEM_LATENCY = 2;
    localparam int LAT_W       = $clog2(MEM_LATENCY + 1);

    // Word index is address bits 7:2
    localparam int RAM_WORDS = 64;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    localparam logic [31:0] DEF_WRITE_BASE = 32'h0000_0000;
    localparam logic [31:0] DEF_READ_BASE  = 32'h0000_0080;
    localparam logic [31:0] DEF_NUM_ADDR   = 32'h0000_00FC;

    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } key_event_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [31:0] write_base;
        logic [31:0] read_base;
        logic [31:0] num_addr;
    } base_cfg_t;

    typedef enum logic [3:0] {
        INIT, IDLE, WRITE, NUM, ASM, DISPLAY, FETCH, FLASH, FINISH
    } loader_state_t;

    typedef enum logic [1:0] {
        WRITE_BASE_SEL,
        READ_BASE_SEL,
        NUM_ADDR_SEL
    } cfg_sel_t;

endpackage
